// ==== design/ccc_executor.sv ====
// Broadcast CCC executor
`default_nettype none
`timescale 1ns/1ps

module ccc_executor (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 ccc_valid_i,
  input  i3c_ccc_pkg::ccc_op_e                 ccc_op_i,
  input  logic                                 def_byte_valid_i,
  input  logic [i3c_ccc_pkg::ByteWidth-1:0]    def_byte_i,
  input  logic                                 ccc_end_i,
  input  logic                                 target_reset_detect_i,
  output logic                                 enec_ibi_o,
  output logic                                 enec_crr_o,
  output logic                                 enec_hj_o,
  output logic                                 disec_ibi_o,
  output logic                                 disec_crr_o,
  output logic                                 disec_hj_o,
  output logic                                 rstdaa_o,
  output logic                                 set_mwl_o,
  output logic [i3c_ccc_pkg::LenWidth-1:0]     mwl_o,
  output logic                                 set_mrl_o,
  output logic [i3c_ccc_pkg::LenWidth-1:0]     mrl_o,
  output logic [i3c_ccc_pkg::ByteWidth-1:0]    rst_action_o,
  output logic                                 rst_action_valid_o,
  output logic                                 plain_reset_pattern_o
);
  import i3c_ccc_pkg::*;

  ccc_op_e              op_q;
  // Defining byte count, saturates at 3
  logic [1:0]           cnt_q;
  logic [ByteWidth-1:0] byte0_q;
  logic [ByteWidth-1:0] byte1_q;
  logic                 armed_q;
  logic                 have_byte;
  logic                 two_bytes;

  assign have_byte = (cnt_q != 2'd0);
  assign two_bytes = (cnt_q == 2'd2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q  <= CccNone;
      cnt_q <= 2'd0;
    end else begin
      if (ccc_end_i) begin
        op_q <= CccNone;
      end
      if (ccc_valid_i) begin
        op_q  <= ccc_op_i;
        cnt_q <= 2'd0;
      end else if (def_byte_valid_i && cnt_q != 2'd3) begin
        cnt_q <= cnt_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (def_byte_valid_i && cnt_q == 2'd0) begin
      byte0_q <= def_byte_i;
    end
    if (def_byte_valid_i && cnt_q == 2'd1) begin
      byte1_q <= def_byte_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_ibi_o            <= 1'b0;
      enec_crr_o            <= 1'b0;
      enec_hj_o             <= 1'b0;
      disec_ibi_o           <= 1'b0;
      disec_crr_o           <= 1'b0;
      disec_hj_o            <= 1'b0;
      rstdaa_o              <= 1'b0;
      set_mwl_o             <= 1'b0;
      mwl_o                 <= '0;
      set_mrl_o             <= 1'b0;
      mrl_o                 <= '0;
      rst_action_o          <= '0;
      rst_action_valid_o    <= 1'b0;
      plain_reset_pattern_o <= 1'b0;
      armed_q               <= 1'b0;
    end else begin
      enec_ibi_o            <= 1'b0;
      enec_crr_o            <= 1'b0;
      enec_hj_o             <= 1'b0;
      disec_ibi_o           <= 1'b0;
      disec_crr_o           <= 1'b0;
      disec_hj_o            <= 1'b0;
      rstdaa_o              <= 1'b0;
      set_mwl_o             <= 1'b0;
      set_mrl_o             <= 1'b0;
      rst_action_valid_o    <= 1'b0;
      plain_reset_pattern_o <= 1'b0;

      // Reset pattern consumes the armed action
      if (target_reset_detect_i) begin
        if (armed_q) begin
          rst_action_valid_o <= 1'b1;
          armed_q            <= 1'b0;
        end else begin
          plain_reset_pattern_o <= 1'b1;
        end
      end

      if (ccc_end_i) begin
        unique case (op_q)
          CccEnec: begin
            enec_ibi_o <= have_byte & byte0_q[EvtIbiBit];
            enec_crr_o <= have_byte & byte0_q[EvtCrrBit];
            enec_hj_o  <= have_byte & byte0_q[EvtHjBit];
          end
          CccDisec: begin
            disec_ibi_o <= have_byte & byte0_q[EvtIbiBit];
            disec_crr_o <= have_byte & byte0_q[EvtCrrBit];
            disec_hj_o  <= have_byte & byte0_q[EvtHjBit];
          end
          CccRstdaa: begin
            rstdaa_o <= 1'b1;
          end
          CccSetmwl: begin
            if (two_bytes) begin
              mwl_o     <= {byte0_q, byte1_q};
              set_mwl_o <= 1'b1;
            end
          end
          CccSetmrl: begin
            if (two_bytes) begin
              mrl_o     <= {byte0_q, byte1_q};
              set_mrl_o <= 1'b1;
            end
          end
          CccRstact: begin
            if (cnt_q == 2'd1) begin
              rst_action_o <= byte0_q;
              armed_q      <= 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/ccc_frame_decoder.sv ====
// Broadcast CCC frame decoder
`default_nettype none
`timescale 1ns/1ps

module ccc_frame_decoder (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 enable_i,
  input  logic                                 start_det_i,
  input  logic                                 stop_det_i,
  input  logic                                 rx_byte_valid_i,
  input  logic [i3c_ccc_pkg::ByteWidth-1:0]    rx_byte_i,
  output logic                                 ccc_valid_o,
  output i3c_ccc_pkg::ccc_op_e                 ccc_op_o,
  output logic                                 def_byte_valid_o,
  output logic [i3c_ccc_pkg::ByteWidth-1:0]    def_byte_o,
  output logic                                 ccc_end_o
);
  import i3c_ccc_pkg::*;

  decode_state_e state_q;
  ccc_op_e       code_op;

  // Map the code byte to an opcode, CccNone if unsupported
  always_comb begin
    unique case (rx_byte_i)
      CccEnecCode:   code_op = CccEnec;
      CccDisecCode:  code_op = CccDisec;
      CccRstdaaCode: code_op = CccRstdaa;
      CccSetmwlCode: code_op = CccSetmwl;
      CccSetmrlCode: code_op = CccSetmrl;
      CccRstactCode: code_op = CccRstact;
      default:       code_op = CccNone;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= DecIdle;
      ccc_valid_o      <= 1'b0;
      ccc_op_o         <= CccNone;
      def_byte_valid_o <= 1'b0;
      ccc_end_o        <= 1'b0;
    end else begin
      ccc_valid_o      <= 1'b0;
      def_byte_valid_o <= 1'b0;
      ccc_end_o        <= 1'b0;

      if (!enable_i) begin
        state_q <= DecIdle;
      end else if (stop_det_i || start_det_i) begin
        // Stop or repeated start closes an open CCC
        if (state_q == DecDefining) begin
          ccc_end_o <= 1'b1;
        end
        state_q <= stop_det_i ? DecIdle : DecAddr;
      end else if (rx_byte_valid_i) begin
        unique case (state_q)
          DecAddr: begin
            state_q <= (rx_byte_i == BroadcastAddrByte) ? DecCode : DecIdle;
          end
          DecCode: begin
            if (code_op != CccNone) begin
              ccc_valid_o <= 1'b1;
              ccc_op_o    <= code_op;
              state_q     <= DecDefining;
            end else begin
              state_q <= DecIdle;
            end
          end
          DecDefining: begin
            def_byte_valid_o <= 1'b1;
          end
          default: begin
            state_q <= DecIdle;
          end
        endcase
      end
    end
  end

  // Defining byte payload, qualified by def_byte_valid_o
  always_ff @(posedge clk_i) begin
    if (rx_byte_valid_i) begin
      def_byte_o <= rx_byte_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/i3c_ccc_pkg.sv ====
// I3C broadcast CCC definitions
`default_nettype none

package i3c_ccc_pkg;

  // Bus byte and length widths
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned LenWidth = 16;

  // Broadcast address 0x7E with write bit
  localparam logic [ByteWidth-1:0] BroadcastAddrByte = 8'hFC;

  // Supported broadcast CCC codes
  localparam logic [ByteWidth-1:0] CccEnecCode = 8'h00;
  localparam logic [ByteWidth-1:0] CccDisecCode = 8'h01;
  localparam logic [ByteWidth-1:0] CccRstdaaCode = 8'h06;
  localparam logic [ByteWidth-1:0] CccSetmwlCode = 8'h09;
  localparam logic [ByteWidth-1:0] CccSetmrlCode = 8'h0A;
  localparam logic [ByteWidth-1:0] CccRstactCode = 8'h2A;

  // Event bits in the ENEC/DISEC mask
  localparam int unsigned EvtIbiBit = 0;
  localparam int unsigned EvtCrrBit = 1;
  localparam int unsigned EvtHjBit = 3;

  // RSTACT defining byte values
  localparam logic [ByteWidth-1:0] RstActPeripheral = 8'h01;
  localparam logic [ByteWidth-1:0] RstActEscalate = 8'h02;

  typedef enum logic [2:0] {
    CccNone,
    CccEnec,
    CccDisec,
    CccRstdaa,
    CccSetmwl,
    CccSetmrl,
    CccRstact
  } ccc_op_e;

  typedef enum logic [1:0] {
    DecIdle,
    DecAddr,
    DecCode,
    DecDefining
  } decode_state_e;

endpackage

`default_nettype wire

// ==== design/i3c_ccc_target.sv ====
// I3C target broadcast CCC top level
`default_nettype none
`timescale 1ns/1ps

module i3c_ccc_target (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 enable_i,
  input  logic                                 start_det_i,
  input  logic                                 stop_det_i,
  input  logic                                 rx_byte_valid_i,
  input  logic [i3c_ccc_pkg::ByteWidth-1:0]    rx_byte_i,
  input  logic                                 target_reset_detect_i,
  input  logic                                 peripheral_reset_done_i,
  output logic                                 enec_ibi_o,
  output logic                                 enec_crr_o,
  output logic                                 enec_hj_o,
  output logic                                 disec_ibi_o,
  output logic                                 disec_crr_o,
  output logic                                 disec_hj_o,
  output logic                                 rstdaa_o,
  output logic                                 set_mwl_o,
  output logic [i3c_ccc_pkg::LenWidth-1:0]     mwl_o,
  output logic                                 set_mrl_o,
  output logic [i3c_ccc_pkg::LenWidth-1:0]     mrl_o,
  output logic [i3c_ccc_pkg::ByteWidth-1:0]    rst_action_o,
  output logic                                 rst_action_valid_o,
  output logic                                 peripheral_reset_o,
  output logic                                 escalated_reset_o
);
  import i3c_ccc_pkg::*;

  logic                 ccc_valid;
  ccc_op_e              ccc_op;
  logic                 def_byte_valid;
  logic [ByteWidth-1:0] def_byte;
  logic                 ccc_end;
  logic                 plain_reset_pattern;

  ccc_frame_decoder ccc_frame_decoder_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .enable_i         (enable_i),
    .start_det_i      (start_det_i),
    .stop_det_i       (stop_det_i),
    .rx_byte_valid_i  (rx_byte_valid_i),
    .rx_byte_i        (rx_byte_i),
    .ccc_valid_o      (ccc_valid),
    .ccc_op_o         (ccc_op),
    .def_byte_valid_o (def_byte_valid),
    .def_byte_o       (def_byte),
    .ccc_end_o        (ccc_end)
  );

  ccc_executor ccc_executor_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .ccc_valid_i           (ccc_valid),
    .ccc_op_i              (ccc_op),
    .def_byte_valid_i      (def_byte_valid),
    .def_byte_i            (def_byte),
    .ccc_end_i             (ccc_end),
    .target_reset_detect_i (target_reset_detect_i),
    .enec_ibi_o            (enec_ibi_o),
    .enec_crr_o            (enec_crr_o),
    .enec_hj_o             (enec_hj_o),
    .disec_ibi_o           (disec_ibi_o),
    .disec_crr_o           (disec_crr_o),
    .disec_hj_o            (disec_hj_o),
    .rstdaa_o              (rstdaa_o),
    .set_mwl_o             (set_mwl_o),
    .mwl_o                 (mwl_o),
    .set_mrl_o             (set_mrl_o),
    .mrl_o                 (mrl_o),
    .rst_action_o          (rst_action_o),
    .rst_action_valid_o    (rst_action_valid_o),
    .plain_reset_pattern_o (plain_reset_pattern)
  );

  target_reset_ctrl target_reset_ctrl_inst (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .rst_action_i            (rst_action_o),
    .rst_action_valid_i      (rst_action_valid_o),
    .plain_reset_pattern_i   (plain_reset_pattern),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o)
  );

endmodule

`default_nettype wire

// ==== design/target_reset_ctrl.sv ====
// Target reset control
`default_nettype none
`timescale 1ns/1ps

module target_reset_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [i3c_ccc_pkg::ByteWidth-1:0]    rst_action_i,
  input  logic                                 rst_action_valid_i,
  input  logic                                 plain_reset_pattern_i,
  input  logic                                 peripheral_reset_done_i,
  output logic                                 peripheral_reset_o,
  output logic                                 escalated_reset_o
);
  import i3c_ccc_pkg::*;

  // Set after the first plain pattern, a second one escalates
  logic escalate_q;
  logic periph_req;
  logic esc_req;

  assign periph_req = (rst_action_valid_i && rst_action_i == RstActPeripheral) ||
                      (plain_reset_pattern_i && !escalate_q);
  assign esc_req = (rst_action_valid_i && rst_action_i == RstActEscalate) ||
                   (plain_reset_pattern_i && escalate_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      escalate_q         <= 1'b0;
      peripheral_reset_o <= 1'b0;
    end else begin
      if (plain_reset_pattern_i && !escalate_q) begin
        escalate_q <= 1'b1;
      end
      if (periph_req) begin
        peripheral_reset_o <= 1'b1;
      end
      if (peripheral_reset_done_i) begin
        escalate_q         <= 1'b0;
        peripheral_reset_o <= 1'b0;
      end
    end
  end

  // Escalated reset is only cleared by the system reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      escalated_reset_o <= 1'b0;
    end else if (esc_req) begin
      escalated_reset_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/i3c_ccc_pkg.sv
design/ccc_frame_decoder.sv
design/ccc_executor.sv
design/target_reset_ctrl.sv
design/i3c_ccc_target.sv
tb/tb_i3c_ccc_target.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the broadcast CCC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_i3c_ccc_target -o sim_tb

output=$(./obj_dir/sim_tb 2>&1) || true
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
  exit 0
fi
exit 1

// ==== tb/tb_i3c_ccc_target.sv ====
// Broadcast CCC target testbench
`default_nettype none
`timescale 1ns/1ps

module tb_i3c_ccc_target;
  import i3c_ccc_pkg::*;

  localparam int ClkPeriod = 8;
  localparam int NumFrames = 44;

  // Scheduled event bits with pulses before level updates
  localparam int EvEnecIbi = 0;
  localparam int EvEnecCrr = 1;
  localparam int EvEnecHj = 2;
  localparam int EvDisecIbi = 3;
  localparam int EvDisecCrr = 4;
  localparam int EvDisecHj = 5;
  localparam int EvRstdaa = 6;
  localparam int EvSetMwl = 7;
  localparam int EvSetMrl = 8;
  localparam int EvRav = 9;
  localparam int EvPeriphSet = 10;
  localparam int EvPeriphClr = 11;
  localparam int EvEscSet = 12;
  localparam int EvLoadMwl = 13;
  localparam int EvLoadMrl = 14;
  localparam int EvLoadAct = 15;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 enable_i;
  logic                 start_det_i;
  logic                 stop_det_i;
  logic                 rx_byte_valid_i;
  logic [ByteWidth-1:0] rx_byte_i;
  logic                 target_reset_detect_i;
  logic                 peripheral_reset_done_i;
  logic                 enec_ibi_o;
  logic                 enec_crr_o;
  logic                 enec_hj_o;
  logic                 disec_ibi_o;
  logic                 disec_crr_o;
  logic                 disec_hj_o;
  logic                 rstdaa_o;
  logic                 set_mwl_o;
  logic [LenWidth-1:0]  mwl_o;
  logic                 set_mrl_o;
  logic [LenWidth-1:0]  mrl_o;
  logic [ByteWidth-1:0] rst_action_o;
  logic                 rst_action_valid_o;
  logic                 peripheral_reset_o;
  logic                 escalated_reset_o;

  // Reference model state
  int                   cyc;
  logic [31:0]          rand_state;
  logic [15:0]          sched_ev [0:255];
  logic [15:0]          sched_len [0:255];
  logic [7:0]           sched_act [0:255];
  logic [7:0]           payload [$];
  logic [15:0]          exp_mwl;
  logic [15:0]          exp_mrl;
  logic [7:0]           exp_act;
  logic                 exp_periph;
  logic                 exp_esc;
  logic                 esc_flag;
  logic                 armed;
  logic [7:0]           armed_act;

  i3c_ccc_target i3c_ccc_target_inst (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .enable_i                (enable_i),
    .start_det_i             (start_det_i),
    .stop_det_i              (stop_det_i),
    .rx_byte_valid_i         (rx_byte_valid_i),
    .rx_byte_i               (rx_byte_i),
    .target_reset_detect_i   (target_reset_detect_i),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .enec_ibi_o              (enec_ibi_o),
    .enec_crr_o              (enec_crr_o),
    .enec_hj_o               (enec_hj_o),
    .disec_ibi_o             (disec_ibi_o),
    .disec_crr_o             (disec_crr_o),
    .disec_hj_o              (disec_hj_o),
    .rstdaa_o                (rstdaa_o),
    .set_mwl_o               (set_mwl_o),
    .mwl_o                   (mwl_o),
    .set_mrl_o               (set_mrl_o),
    .mrl_o                   (mrl_o),
    .rst_action_o            (rst_action_o),
    .rst_action_valid_o      (rst_action_valid_o),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  function automatic logic [7:0] slot_of(int c);
    return c[7:0];
  endfunction

  function automatic logic [7:0] rand_byte();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state[23:16];
  endfunction

  function automatic logic is_supported(logic [7:0] code);
    case (code)
      CccEnecCode, CccDisecCode, CccRstdaaCode: return 1'b1;
      CccSetmwlCode, CccSetmrlCode, CccRstactCode: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [7:0] unsupported_code();
    logic [7:0] code;
    code = rand_byte();
    while (is_supported(code)) begin
      code = rand_byte();
    end
    return code;
  endfunction

  function automatic logic [7:0] other_addr();
    logic [7:0] addr;
    addr = rand_byte();
    if (addr == BroadcastAddrByte) begin
      addr = 8'h7C;
    end
    return addr;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic add_event(input int at, input int idx);
    sched_ev[slot_of(at)][idx] = 1'b1;
  endtask

  // Compare every output against the model once per cycle
  always @(negedge clk_i) begin : compare_outputs
    logic [15:0] ev;
    ev = sched_ev[slot_of(cyc)];
    sched_ev[slot_of(cyc)] = '0;
    if (rst_ni) begin
      if (ev[EvPeriphSet]) exp_periph = 1'b1;
      if (ev[EvPeriphClr]) exp_periph = 1'b0;
      if (ev[EvEscSet]) exp_esc = 1'b1;
      if (ev[EvLoadMwl]) exp_mwl = sched_len[slot_of(cyc)];
      if (ev[EvLoadMrl]) exp_mrl = sched_len[slot_of(cyc)];
      if (ev[EvLoadAct]) exp_act = sched_act[slot_of(cyc)];
      check_bit("enec_ibi_o", enec_ibi_o, ev[EvEnecIbi]);
      check_bit("enec_crr_o", enec_crr_o, ev[EvEnecCrr]);
      check_bit("enec_hj_o", enec_hj_o, ev[EvEnecHj]);
      check_bit("disec_ibi_o", disec_ibi_o, ev[EvDisecIbi]);
      check_bit("disec_crr_o", disec_crr_o, ev[EvDisecCrr]);
      check_bit("disec_hj_o", disec_hj_o, ev[EvDisecHj]);
      check_bit("rstdaa_o", rstdaa_o, ev[EvRstdaa]);
      check_bit("set_mwl_o", set_mwl_o, ev[EvSetMwl]);
      check_bit("set_mrl_o", set_mrl_o, ev[EvSetMrl]);
      check_bit("rst_action_valid_o", rst_action_valid_o, ev[EvRav]);
      check_word("mwl_o", mwl_o, exp_mwl);
      check_word("mrl_o", mrl_o, exp_mrl);
      check_word("rst_action_o", {8'd0, rst_action_o}, {8'd0, exp_act});
      check_bit("peripheral_reset_o", peripheral_reset_o, exp_periph);
      check_bit("escalated_reset_o", escalated_reset_o, exp_esc);
    end
  end

  // Escalated reset never drops while out of reset
  assert property (@(posedge clk_i)
    !(rst_ni && $past(rst_ni) && $past(escalated_reset_o) && !escalated_reset_o))
  else begin
    $display("CHECK FAILED escalated_reset_o got 0x%0h expected 0x1", escalated_reset_o);
    $display("Some tests failed");
    $fatal(1);
  end

  task automatic apply_reset();
    @(posedge clk_i);
    #1;
    rst_ni = 1'b0;
    exp_mwl = '0;
    exp_mrl = '0;
    exp_act = '0;
    exp_periph = 1'b0;
    exp_esc = 1'b0;
    esc_flag = 1'b0;
    armed = 1'b0;
    armed_act = '0;
    for (int i = 0; i < 256; i++) begin
      sched_ev[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  // One cycle with all strobes low
  task automatic step();
    @(posedge clk_i);
    #1;
    start_det_i = 1'b0;
    stop_det_i = 1'b0;
    rx_byte_valid_i = 1'b0;
    target_reset_detect_i = 1'b0;
    peripheral_reset_done_i = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic send_byte(input logic [7:0] b);
    step();
    rx_byte_valid_i = 1'b1;
    rx_byte_i = b;
  endtask

  task automatic load_payload(input int n);
    payload.delete();
    repeat (n) payload.push_back(rand_byte());
  endtask

  // Predict the commit two cycles after the closing strobe
  task automatic expect_commit(input int at, input logic [7:0] addr, input logic [7:0] code);
    logic [15:0] ev;
    int n;
    ev = '0;
    n = payload.size();
    if (!enable_i || addr != BroadcastAddrByte) return;
    case (code)
      CccEnecCode: if (n > 0) begin
        ev[EvEnecIbi] = payload[0][EvtIbiBit];
        ev[EvEnecCrr] = payload[0][EvtCrrBit];
        ev[EvEnecHj] = payload[0][EvtHjBit];
      end
      CccDisecCode: if (n > 0) begin
        ev[EvDisecIbi] = payload[0][EvtIbiBit];
        ev[EvDisecCrr] = payload[0][EvtCrrBit];
        ev[EvDisecHj] = payload[0][EvtHjBit];
      end
      CccRstdaaCode: ev[EvRstdaa] = 1'b1;
      CccSetmwlCode: if (n == 2) begin
        ev[EvSetMwl] = 1'b1;
        ev[EvLoadMwl] = 1'b1;
        sched_len[slot_of(at)] = {payload[0], payload[1]};
      end
      CccSetmrlCode: if (n == 2) begin
        ev[EvSetMrl] = 1'b1;
        ev[EvLoadMrl] = 1'b1;
        sched_len[slot_of(at)] = {payload[0], payload[1]};
      end
      CccRstactCode: if (n == 1) begin
        ev[EvLoadAct] = 1'b1;
        sched_act[slot_of(at)] = payload[0];
        armed = 1'b1;
        armed_act = payload[0];
      end
      default: begin
      end
    endcase
    sched_ev[slot_of(at)] = sched_ev[slot_of(at)] | ev;
  endtask

  // Address, code and payload closed by a stop or a repeated start
  task automatic ccc_body(input logic [7:0] addr, input logic [7:0] code, input logic use_stop);
    send_byte(addr);
    send_byte(code);
    foreach (payload[j]) send_byte(payload[j]);
    step();
    if (use_stop) begin
      stop_det_i = 1'b1;
    end else begin
      start_det_i = 1'b1;
    end
    expect_commit(cyc + 2, addr, code);
  endtask

  task automatic run_frame(input logic [7:0] addr, input logic [7:0] code);
    step();
    start_det_i = 1'b1;
    ccc_body(addr, code, 1'b1);
    idle(3);
  endtask

  task automatic reset_pattern();
    step();
    target_reset_detect_i = 1'b1;
    if (armed) begin
      add_event(cyc + 1, EvRav);
      armed = 1'b0;
      if (armed_act == RstActPeripheral) add_event(cyc + 2, EvPeriphSet);
      if (armed_act == RstActEscalate) add_event(cyc + 2, EvEscSet);
    end else if (!esc_flag) begin
      add_event(cyc + 2, EvPeriphSet);
      esc_flag = 1'b1;
    end else begin
      add_event(cyc + 2, EvEscSet);
    end
    idle(4);
  endtask

  task automatic reset_done();
    step();
    peripheral_reset_done_i = 1'b1;
    add_event(cyc + 1, EvPeriphClr);
    esc_flag = 1'b0;
    idle(2);
  endtask

  initial begin : watchdog
    #(NumFrames * 64 * ClkPeriod);
    $display("Simulation timed out before all tests finished");
    $display("Some tests failed");
    $fatal(1);
  end

  initial begin : main
    clk_i = 1'b0;
    rst_ni = 1'b0;
    enable_i = 1'b0;
    start_det_i = 1'b0;
    stop_det_i = 1'b0;
    rx_byte_valid_i = 1'b0;
    rx_byte_i = '0;
    target_reset_detect_i = 1'b0;
    peripheral_reset_done_i = 1'b0;
    cyc = 0;
    rand_state = 32'd82;
    apply_reset();
    enable_i = 1'b1;
    idle(2);

    // Event masks and length values
    for (int i = 0; i < 6; i++) begin
      load_payload(1);
      run_frame(BroadcastAddrByte, CccEnecCode);
      load_payload(1);
      run_frame(BroadcastAddrByte, CccDisecCode);
      load_payload(2);
      run_frame(BroadcastAddrByte, CccSetmwlCode);
      load_payload(2);
      run_frame(BroadcastAddrByte, CccSetmrlCode);
    end
    load_payload(1);
    run_frame(BroadcastAddrByte, CccSetmwlCode);
    load_payload(3);
    run_frame(BroadcastAddrByte, CccSetmwlCode);
    load_payload(1);
    run_frame(BroadcastAddrByte, CccSetmrlCode);
    load_payload(3);
    run_frame(BroadcastAddrByte, CccSetmrlCode);

    // Frames that must be ignored
    for (int i = 0; i < 4; i++) begin
      load_payload(2);
      run_frame(other_addr(), CccSetmwlCode);
      run_frame(BroadcastAddrByte, unsupported_code());
      enable_i = 1'b0;
      payload.delete();
      payload.push_back(8'hFF);
      run_frame(BroadcastAddrByte, CccEnecCode);
      enable_i = 1'b1;
      idle(2);
    end

    // RSTDAA followed by two CCCs joined by a repeated start
    payload.delete();
    run_frame(BroadcastAddrByte, CccRstdaaCode);
    step();
    start_det_i = 1'b1;
    ccc_body(BroadcastAddrByte, CccRstdaaCode, 1'b0);
    load_payload(1);
    ccc_body(BroadcastAddrByte, CccEnecCode, 1'b1);
    idle(3);

    // Armed reset actions
    payload.delete();
    payload.push_back(RstActPeripheral);
    run_frame(BroadcastAddrByte, CccRstactCode);
    reset_pattern();
    idle(4);
    reset_done();
    payload.delete();
    payload.push_back(RstActEscalate);
    run_frame(BroadcastAddrByte, CccRstactCode);
    reset_pattern();
    apply_reset();
    idle(2);

    // Plain patterns with and without done in between
    reset_pattern();
    reset_done();
    reset_pattern();
    reset_done();
    reset_pattern();
    reset_pattern();
    reset_done();
    idle(4);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
